// File: rtl/blob_tracker_params.svh
`ifndef BLOB_TRACKER_PARAMS_SVH
`define BLOB_TRACKER_PARAMS_SVH

// camera side widths
`define CAM_DATA_W 8      // parallel camera byte
`define HCOUNT_W   11     // up to 2047 pixels per line
`define VCOUNT_W   10     // up to 1023 lines

// centre of mass accumulators
`define SUM_W      32     // holds the coordinate sum of a full 1280x720 frame
`define CNT_W      20     // masked pixel count, 1280*720 fits

// apb bus
`define APB_ADDR_W 8
`define APB_DATA_W 32

// register map, byte addresses
`define REG_CTRL   8'h00  // track_en, channel_sel
`define REG_LOWER  8'h04
`define REG_UPPER  8'h08
`define REG_COM    8'h0C  // read only, x/y result

// pink range as a power-up default
`define LOWER_RESET 8'hA0
`define UPPER_RESET 8'hF0

`endif

// File: rtl/blob_tracker_pkg.sv
`include "blob_tracker_params.svh"

package blob_tracker_pkg;

   // camera pixel, high byte arrives first
   typedef struct packed {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
   } rgb565_t;

   typedef logic [`HCOUNT_W-1:0] hcount_t;  // pixel index in a line
   typedef logic [`VCOUNT_W-1:0] vcount_t;  // line index in a frame

   // channel used by the threshold stage
   // code 2'd3 is not listed and falls back to red
   typedef enum logic [1:0] {
      CH_RED   = 2'd0,
      CH_GREEN = 2'd1,
      CH_BLUE  = 2'd2
   } channel_sel_e;

endpackage

// File: rtl/pixel_if.sv
`timescale 1ns/1ps

// pixel or mask stream, one item per clock at most, no back-pressure
interface pixel_if;

   logic                       valid;      // pixel qualifier
   blob_tracker_pkg::hcount_t  hcount;     // column of this pixel
   blob_tracker_pkg::vcount_t  vcount;     // row of this pixel
   blob_tracker_pkg::rgb565_t  pixel;      // colour, or mask in bit 0
   logic                       frame_end;  // single pulse after the last pixel

   modport producer (
      output valid,
      output hcount,
      output vcount,
      output pixel,
      output frame_end
   );

   modport consumer (
      input valid,
      input hcount,
      input vcount,
      input pixel,
      input frame_end
   );

endinterface

// File: rtl/serial_divider.sv
`timescale 1ns/1ps

module serial_divider #(
   parameter int DIVIDEND_W = 32,
   parameter int DIVISOR_W  = 20
) (
   input  logic                  clk_camera,
   input  logic                  sys_rst_camera,
   input  logic                  start_i,
   input  logic [DIVIDEND_W-1:0] dividend_i,
   input  logic [DIVISOR_W-1:0]  divisor_i,
   output logic [DIVIDEND_W-1:0] quotient_o,  // floor, stable after done_o
   output logic                  done_o
);

   localparam int STEP_W = $clog2(DIVIDEND_W);

   logic [DIVISOR_W-1:0] rem;        // partial remainder, always below divisor
   logic [DIVISOR_W-1:0] div_r;      // latched divisor
   logic [DIVISOR_W:0]   shifted;    // remainder with next dividend bit
   logic [DIVISOR_W:0]   diff;
   logic [STEP_W-1:0]    step;
   logic                 busy;

   // quotient_o doubles as the dividend shift register
   assign shifted = {rem, quotient_o[DIVIDEND_W-1]};
   assign diff    = shifted - {1'b0, div_r};  // msb set means no subtract

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         busy   <= 1'b0;
         done_o <= 1'b0;
         step   <= '0;
      end else begin
         done_o <= 1'b0;
         if (start_i) begin
            busy <= 1'b1;
            step <= '0;
         end else if (busy) begin
            step <= step + STEP_W'(1);
            if (step == STEP_W'(DIVIDEND_W - 1)) begin
               busy   <= 1'b0;  // last quotient bit this cycle
               done_o <= 1'b1;
            end
         end
      end
   end

   // one restoring step per clock, msb first
   always_ff @(posedge clk_camera) begin
      if (start_i) begin
         rem        <= '0;
         div_r      <= divisor_i;
         quotient_o <= dividend_i;
      end else if (busy) begin
         if (!diff[DIVISOR_W]) begin
            rem        <= diff[DIVISOR_W-1:0];
            quotient_o <= {quotient_o[DIVIDEND_W-2:0], 1'b1};
         end else begin
            rem        <= shifted[DIVISOR_W-1:0];
            quotient_o <= {quotient_o[DIVIDEND_W-2:0], 1'b0};
         end
      end
   end

endmodule

// File: rtl/pixel_reconstruct.sv
`timescale 1ns/1ps
`include "blob_tracker_params.svh"

module pixel_reconstruct import blob_tracker_pkg::*; (
   input  logic                   clk_camera,
   input  logic                   sys_rst_camera,
   input  logic [`CAM_DATA_W-1:0] cam_d_i,
   input  logic                   cam_pclk_i,
   input  logic                   cam_hsync_i,
   input  logic                   cam_vsync_i,
   pixel_if.producer              pix_o
);

   logic [`CAM_DATA_W-1:0] d_sync [2];  // [1] is the second stage
   logic [1:0]             pclk_sync;
   logic [1:0]             hs_sync;
   logic [1:0]             vs_sync;
   logic [`CAM_DATA_W-1:0] d_r;         // data aligned with the edge flags
   logic                   pclk_prev;
   logic                   hs_prev;     // also the aligned hsync level
   logic                   vs_prev;     // also the aligned vsync level
   logic                   pclk_rise;
   logic                   hs_fall;
   logic                   vs_rise;
   logic                   take_byte;
   logic                   phase;       // 1 once the high byte is held
   logic [`CAM_DATA_W-1:0] first_byte;
   hcount_t                h_cnt;
   vcount_t                v_cnt;

   // two flop synchronizers into clk_camera
   always_ff @(posedge clk_camera) begin
      d_sync[0] <= cam_d_i;
      d_sync[1] <= d_sync[0];
      pclk_sync <= {pclk_sync[0], cam_pclk_i};
      hs_sync   <= {hs_sync[0], cam_hsync_i};
      vs_sync   <= {vs_sync[0], cam_vsync_i};
   end

   // registered edge detect, third cycle after the port
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pclk_prev <= 1'b0;
         hs_prev   <= 1'b0;
         vs_prev   <= 1'b0;
         pclk_rise <= 1'b0;
         hs_fall   <= 1'b0;
         vs_rise   <= 1'b0;
      end else begin
         pclk_prev <= pclk_sync[1];
         hs_prev   <= hs_sync[1];
         vs_prev   <= vs_sync[1];
         pclk_rise <= pclk_sync[1] & ~pclk_prev;
         hs_fall   <= ~hs_sync[1] & hs_prev;
         vs_rise   <= vs_sync[1] & ~vs_prev;
      end
      d_r <= d_sync[1];
   end

   assign take_byte = pclk_rise & hs_prev & ~vs_prev;  // active video only

   // byte pairing and line/frame counting
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pix_o.valid     <= 1'b0;
         pix_o.frame_end <= 1'b0;
         phase           <= 1'b0;
         h_cnt           <= '0;
         v_cnt           <= '0;
      end else begin
         pix_o.valid     <= 1'b0;
         pix_o.frame_end <= vs_rise;  // same delay as a pixel
         if (vs_rise) begin
            v_cnt <= '0;
            h_cnt <= '0;
            phase <= 1'b0;
         end else if (hs_fall) begin  // end of line
            v_cnt <= v_cnt + vcount_t'(1);
            h_cnt <= '0;
            phase <= 1'b0;
         end else if (take_byte) begin
            phase <= ~phase;
            if (phase) begin
               pix_o.valid <= 1'b1;  // low byte completes the pixel
               h_cnt       <= h_cnt + hcount_t'(1);
            end
         end
      end
   end

   // payload path
   always_ff @(posedge clk_camera) begin
      if (take_byte) begin
         if (!phase) begin
            first_byte <= d_r;
         end else begin
            pix_o.pixel  <= rgb565_t'({first_byte, d_r});
            pix_o.hcount <= h_cnt;
            pix_o.vcount <= v_cnt;
         end
      end
   end

endmodule

// File: rtl/color_threshold.sv
`timescale 1ns/1ps

module color_threshold import blob_tracker_pkg::*; (
   input  logic         clk_camera,
   input  logic         sys_rst_camera,
   pixel_if.consumer    pix_i,
   input  logic [7:0]   lower_bound_i,  // inclusive
   input  logic [7:0]   upper_bound_i,  // inclusive
   input  channel_sel_e channel_sel_i,
   input  logic         track_en_i,
   pixel_if.producer    mask_o          // mask in pixel bit 0
);

   logic [7:0] chan_val;  // selected channel scaled to 8 bits
   logic       in_range;

   // pad the chosen channel with zeros up to 8 bits
   always_comb begin
      case (channel_sel_i)
         CH_GREEN: chan_val = {pix_i.pixel.green, 2'b00};
         CH_BLUE:  chan_val = {pix_i.pixel.blue, 3'b000};
         default:  chan_val = {pix_i.pixel.red, 3'b000};  // red and spare code
      endcase
   end

   assign in_range = track_en_i
                     && (chan_val >= lower_bound_i)
                     && (chan_val <= upper_bound_i);

   // stream qualifiers, one cycle through
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         mask_o.valid     <= 1'b0;
         mask_o.frame_end <= 1'b0;
      end else begin
         mask_o.valid     <= pix_i.valid;
         mask_o.frame_end <= pix_i.frame_end;
      end
   end

   // counts travel with the mask bit
   always_ff @(posedge clk_camera) begin
      mask_o.hcount <= pix_i.hcount;
      mask_o.vcount <= pix_i.vcount;
      mask_o.pixel  <= rgb565_t'({15'b0, in_range});
   end

endmodule

// File: rtl/center_of_mass.sv
`timescale 1ns/1ps
`include "blob_tracker_params.svh"

module center_of_mass import blob_tracker_pkg::*; (
   input  logic      clk_camera,
   input  logic      sys_rst_camera,
   pixel_if.consumer mask_i,
   output hcount_t   x_com_o,
   output vcount_t   y_com_o,
   output logic      com_valid_o   // single pulse per new result
);

   logic [`SUM_W-1:0] sum_x;
   logic [`SUM_W-1:0] sum_y;
   logic [`CNT_W-1:0] mask_cnt;
   logic              hit;         // masked pixel this cycle
   logic              div_start;
   logic [`SUM_W-1:0] x_quot;
   logic [`SUM_W-1:0] y_quot;
   logic              x_done;
   logic              y_done;

   assign hit       = mask_i.valid & mask_i.pixel[0];
   assign div_start = mask_i.frame_end & (mask_cnt != '0);  // empty frame keeps old result

   // per frame sums, cleared once the dividers have taken them
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         sum_x    <= '0;
         sum_y    <= '0;
         mask_cnt <= '0;
      end else if (mask_i.frame_end) begin
         sum_x    <= '0;
         sum_y    <= '0;
         mask_cnt <= '0;
      end else if (hit) begin
         sum_x    <= sum_x + `SUM_W'(mask_i.hcount);
         sum_y    <= sum_y + `SUM_W'(mask_i.vcount);
         mask_cnt <= mask_cnt + `CNT_W'(1);
      end
   end

   // dividers latch their operands on start, next frame may accumulate meanwhile
   serial_divider #(
      .DIVIDEND_W (`SUM_W),
      .DIVISOR_W  (`CNT_W)
   ) x_div (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (div_start),
      .dividend_i     (sum_x),
      .divisor_i      (mask_cnt),
      .quotient_o     (x_quot),
      .done_o         (x_done)
   );

   serial_divider #(
      .DIVIDEND_W (`SUM_W),
      .DIVISOR_W  (`CNT_W)
   ) y_div (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (div_start),
      .dividend_i     (sum_y),
      .divisor_i      (mask_cnt),
      .quotient_o     (y_quot),
      .done_o         (y_done)
   );

   // result register, mean never exceeds the coordinate range
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         x_com_o     <= '0;
         y_com_o     <= '0;
         com_valid_o <= 1'b0;
      end else begin
         com_valid_o <= x_done & y_done;
         if (x_done && y_done) begin
            x_com_o <= x_quot[`HCOUNT_W-1:0];
            y_com_o <= y_quot[`VCOUNT_W-1:0];
         end
      end
   end

endmodule

// File: rtl/apb_config_regs.sv
`timescale 1ns/1ps
`include "blob_tracker_params.svh"

module apb_config_regs import blob_tracker_pkg::*; (
   input  logic                   clk_camera,
   input  logic                   sys_rst_camera,
   input  logic [`APB_ADDR_W-1:0] paddr_i,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  logic [`APB_DATA_W-1:0] pwdata_i,
   input  hcount_t                x_com_i,
   input  vcount_t                y_com_i,
   output logic [`APB_DATA_W-1:0] prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output logic [7:0]             lower_bound_o,
   output logic [7:0]             upper_bound_o,
   output channel_sel_e           channel_sel_o,
   output logic                   track_en_o
);

   logic access;    // apb access phase
   logic addr_hit;  // address is in the map

   assign access   = psel_i & penable_i;
   assign pready_o = 1'b1;  // zero wait states

   // read mux and decode, valid during the access phase
   always_comb begin
      addr_hit = 1'b1;
      prdata_o = '0;
      case (paddr_i)
         `REG_CTRL: begin
            prdata_o[0]   = track_en_o;
            prdata_o[2:1] = channel_sel_o;
         end
         `REG_LOWER: prdata_o[7:0] = lower_bound_o;
         `REG_UPPER: prdata_o[7:0] = upper_bound_o;
         `REG_COM: begin
            prdata_o[`HCOUNT_W-1:0]  = x_com_i;
            prdata_o[16+:`VCOUNT_W]  = y_com_i;  // y in the upper half
         end
         default: addr_hit = 1'b0;
      endcase
   end

   assign pslverr_o = access & ~addr_hit;

   // config writes land on the access edge
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         track_en_o    <= 1'b0;
         channel_sel_o <= CH_RED;
         lower_bound_o <= `LOWER_RESET;
         upper_bound_o <= `UPPER_RESET;
      end else if (access && pwrite_i) begin
         case (paddr_i)
            `REG_CTRL: begin
               track_en_o    <= pwdata_i[0];
               channel_sel_o <= channel_sel_e'(pwdata_i[2:1]);
            end
            `REG_LOWER: lower_bound_o <= pwdata_i[7:0];
            `REG_UPPER: upper_bound_o <= pwdata_i[7:0];
            default: ;  // COM is read only, unmapped ignored
         endcase
      end
   end

endmodule

// File: rtl/blob_tracker_top.sv
`timescale 1ns/1ps
`include "blob_tracker_params.svh"

module blob_tracker_top import blob_tracker_pkg::*; (
   input  logic                   clk_camera,
   input  logic                   sys_rst_camera,
   input  logic [`CAM_DATA_W-1:0] cam_d_i,
   input  logic                   cam_pclk_i,
   input  logic                   cam_hsync_i,
   input  logic                   cam_vsync_i,
   input  logic [`APB_ADDR_W-1:0] paddr_i,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  logic [`APB_DATA_W-1:0] pwdata_i,
   output logic [`APB_DATA_W-1:0] prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output logic                   com_valid_o,
   output hcount_t                x_com_o,
   output vcount_t                y_com_o
);

   logic [7:0]   lower_bound;
   logic [7:0]   upper_bound;
   channel_sel_e channel_sel;
   logic         track_en;

   pixel_if pix_stream ();   // rgb565 pixels from the camera
   pixel_if mask_stream ();  // one bit mask per pixel

   pixel_reconstruct pixel_reconstruct_inst (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_d_i        (cam_d_i),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .pix_o          (pix_stream.producer)
   );

   color_threshold color_threshold_inst (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .pix_i          (pix_stream.consumer),
      .lower_bound_i  (lower_bound),
      .upper_bound_i  (upper_bound),
      .channel_sel_i  (channel_sel),
      .track_en_i     (track_en),
      .mask_o         (mask_stream.producer)
   );

   center_of_mass center_of_mass_inst (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .mask_i         (mask_stream.consumer),
      .x_com_o        (x_com_o),
      .y_com_o        (y_com_o),
      .com_valid_o    (com_valid_o)
   );

   apb_config_regs apb_config_regs_inst (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .paddr_i        (paddr_i),
      .psel_i         (psel_i),
      .penable_i      (penable_i),
      .pwrite_i       (pwrite_i),
      .pwdata_i       (pwdata_i),
      .x_com_i        (x_com_o),  // status readback of the last result
      .y_com_i        (y_com_o),
      .prdata_o       (prdata_o),
      .pready_o       (pready_o),
      .pslverr_o      (pslverr_o),
      .lower_bound_o  (lower_bound),
      .upper_bound_o  (upper_bound),
      .channel_sel_o  (channel_sel),
      .track_en_o     (track_en)
   );

endmodule

// File: tb/tb_blob_tracker.sv
`timescale 1ns/1ps
`include "blob_tracker_params.svh"

module tb_blob_tracker;

   localparam int CLK_PERIOD   = 8;
   localparam int SEED         = 44556;
   localparam int PIX          = 16;     // pixels per line
   localparam int LINES        = 8;      // lines per frame
   localparam int COM_WINDOW   = 60;     // cycles allowed from vsync rise to com_valid_o
   localparam int NUM_FRAMES   = 7;
   localparam int FRAME_CYC    = LINES * (PIX * 16 + 8) + COM_WINDOW + 8;
   localparam int WATCHDOG_CYC = NUM_FRAMES * FRAME_CYC + 2000;  // frames plus apb and reset

   logic        clk_camera = 1'b0;
   logic        sys_rst_camera;
   logic [7:0]  cam_d;
   logic        cam_pclk;
   logic        cam_hsync;
   logic        cam_vsync;
   logic [7:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata_o;
   logic        pready_o;
   logic        pslverr_o;
   logic        com_valid_o;
   logic [10:0] x_com_o;
   logic [9:0]  y_com_o;

   int          errors = 0;
   int          checks = 0;
   logic        quiet = 1'b0;  // no result may appear while set
   int          rx0 [2];       // inclusive rectangle bounds
   int          rx1 [2];
   int          ry0 [2];
   int          ry1 [2];
   logic [15:0] rcol [2];      // rgb565 fill of each rectangle
   int          ex;
   int          ey;

   always #(CLK_PERIOD / 2) clk_camera = ~clk_camera;

   blob_tracker_top blob_tracker_top_inst (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_d_i        (cam_d),
      .cam_pclk_i     (cam_pclk),
      .cam_hsync_i    (cam_hsync),
      .cam_vsync_i    (cam_vsync),
      .paddr_i        (paddr),
      .psel_i         (psel),
      .penable_i      (penable),
      .pwrite_i       (pwrite),
      .pwdata_i       (pwdata),
      .prdata_o       (prdata_o),
      .pready_o       (pready_o),
      .pslverr_o      (pslverr_o),
      .com_valid_o    (com_valid_o),
      .x_com_o        (x_com_o),
      .y_com_o        (y_com_o)
   );

   // zero wait state slave
   assert property (@(posedge clk_camera) disable iff (sys_rst_camera) pready_o)
      else begin
         $display("ERROR pready_o got 0x%0h expected 0x1", pready_o);
         errors++;
      end

   // result strobe is a single cycle pulse
   assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
                    com_valid_o |=> !com_valid_o)
      else begin
         $display("ERROR com_valid_o high for more than one cycle");
         errors++;
      end

   assert property (@(posedge clk_camera) disable iff (sys_rst_camera) !(quiet && com_valid_o))
      else begin
         $display("ERROR com_valid_o got 0x1 expected 0x0 in a frame without a result");
         errors++;
      end

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
         else begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
         end
   endtask

   // all tasks below start and end just after a falling edge
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input bit exp_err);
      paddr   = addr;
      pwdata  = data;
      pwrite  = 1'b1;
      psel    = 1'b1;  // setup phase
      penable = 1'b0;
      @(negedge clk_camera);
      penable = 1'b1;  // access phase
      #2;
      check_eq("pslverr_o", 32'(pslverr_o), 32'(exp_err));
      @(negedge clk_camera);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
                           input bit exp_err);
      paddr   = addr;
      pwrite  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk_camera);
      penable = 1'b1;
      #2;                                   // mid low phase so the comb read data has settled
      check_eq("pslverr_o", 32'(pslverr_o), 32'(exp_err));
      if (!exp_err) begin
         check_eq("prdata_o", prdata_o, exp_data);
      end
      @(negedge clk_camera);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   function automatic logic [31:0] com_word(input int x, input int y);
      return (32'(y) << 16) | 32'(x);       // COM layout with y in the upper half
   endfunction

   function automatic logic [15:0] pixel_at(input int x, input int y);
      logic [15:0] px;
      px = 16'h0000;                        // black background
      for (int r = 0; r < 2; r++) begin
         if (x >= rx0[r] && x <= rx1[r] && y >= ry0[r] && y <= ry1[r]) begin
            px = rcol[r];
         end
      end
      return px;
   endfunction

   task automatic clear_rects();
      for (int r = 0; r < 2; r++) begin
         rx0[r] = 1;                        // x0 above x1 leaves it empty
         rx1[r] = 0;
         ry0[r] = 0;
         ry1[r] = 0;
         rcol[r] = 16'h0000;
      end
   endtask

   task automatic place_rect(input int r, input int x_lo, input int x_hi, input logic [15:0] col);
      rx0[r]  = $urandom_range(x_hi, x_lo);
      rx1[r]  = $urandom_range(x_hi, rx0[r]);
      ry0[r]  = $urandom_range(LINES - 1, 0);
      ry1[r]  = $urandom_range(LINES - 1, ry0[r]);
      rcol[r] = col;
   endtask

   // one camera byte with the pixel clock 4 cycles low then 4 cycles high
   task automatic send_byte(input logic [7:0] b);
      cam_d    = b;
      cam_pclk = 1'b0;
      repeat (4) @(negedge clk_camera);
      cam_pclk = 1'b1;                      // sampled on this rise
      repeat (4) @(negedge clk_camera);
   endtask

   task automatic draw_lines();
      logic [15:0] px;
      for (int y = 0; y < LINES; y++) begin
         cam_hsync = 1'b1;
         repeat (2) @(negedge clk_camera);
         for (int x = 0; x < PIX; x++) begin
            px = pixel_at(x, y);
            send_byte(px[15:8]);            // high byte first
            send_byte(px[7:0]);
         end
         cam_pclk  = 1'b0;
         cam_hsync = 1'b0;                  // line end bumps vcount
         repeat (6) @(negedge clk_camera);
      end
   endtask

   task automatic run_frame(input bit expect_pulse, input int exp_x, input int exp_y);
      bit seen;
      seen  = 1'b0;
      quiet = !expect_pulse;
      draw_lines();
      cam_vsync = 1'b1;                     // frame end
      for (int c = 0; c < COM_WINDOW && !seen; c++) begin
         @(negedge clk_camera);
         if (com_valid_o && expect_pulse) begin
            seen = 1'b1;
            check_eq("x_com_o", 32'(x_com_o), 32'(exp_x));
            check_eq("y_com_o", 32'(y_com_o), 32'(exp_y));
         end
      end
      if (expect_pulse) begin
         assert (seen)
            else begin
               $display("com_valid_o did not pulse within %0d cycles of vsync rise", COM_WINDOW);
               errors++;
            end
      end
      cam_vsync = 1'b0;
      repeat (8) @(negedge clk_camera);
      quiet = 1'b0;
   endtask

   // limit is the length of all frames plus a margin
   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, errors so far %0d", WATCHDOG_CYC, errors);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      void'($urandom(SEED));
      sys_rst_camera = 1'b1;
      cam_d     = 8'h00;
      cam_pclk  = 1'b0;
      cam_hsync = 1'b0;
      cam_vsync = 1'b0;
      paddr     = 8'h00;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      pwdata    = 32'h0;
      clear_rects();
      repeat (16) @(negedge clk_camera);
      sys_rst_camera = 1'b0;

      // reset values
      check_eq("com_valid_o", 32'(com_valid_o), 32'h0);
      check_eq("pslverr_o", 32'(pslverr_o), 32'h0);
      check_eq("pready_o", 32'(pready_o), 32'h1);
      apb_read(`REG_CTRL, 32'h0, 1'b0);
      apb_read(`REG_LOWER, 32'(`LOWER_RESET), 1'b0);
      apb_read(`REG_UPPER, 32'(`UPPER_RESET), 1'b0);

      // register access
      apb_write(`REG_CTRL, 32'h5, 1'b0);   // enable with blue
      apb_write(`REG_LOWER, 32'h5A, 1'b0);
      apb_write(`REG_UPPER, 32'hC3, 1'b0);
      apb_read(`REG_CTRL, 32'h5, 1'b0);
      apb_read(`REG_LOWER, 32'h5A, 1'b0);
      apb_read(`REG_UPPER, 32'hC3, 1'b0);
      apb_write(8'h10, 32'h1234, 1'b1);     // unmapped
      apb_read(8'h20, 32'h0, 1'b1);
      apb_write(`REG_COM, 32'hFFFF_FFFF, 1'b0);
      apb_read(`REG_COM, 32'h0, 1'b0);
      apb_read(`REG_CTRL, 32'h5, 1'b0);    // untouched by the two writes above
      apb_read(`REG_LOWER, 32'h5A, 1'b0);
      apb_read(`REG_UPPER, 32'hC3, 1'b0);

      // red rectangles where red 0x1f expands to 0xf8
      apb_write(`REG_LOWER, 32'h80, 1'b0);
      apb_write(`REG_UPPER, 32'hFF, 1'b0);
      apb_write(`REG_CTRL, 32'h1, 1'b0);
      for (int f = 0; f < 3; f++) begin
         clear_rects();
         place_rect(0, 0, PIX - 1, 16'hF800);
         ex = (rx0[0] + rx1[0]) / 2;        // mean of a solid box is its midpoint floored
         ey = (ry0[0] + ry1[0]) / 2;
         run_frame(1'b1, ex, ey);
         apb_read(`REG_COM, com_word(ex, ey), 1'b0);
      end

      // green box on the left and blue box on the right
      clear_rects();
      place_rect(0, 0, PIX / 2 - 1, 16'h07E0);
      place_rect(1, PIX / 2, PIX - 1, 16'h001F);
      apb_write(`REG_CTRL, 32'h3, 1'b0);
      ex = (rx0[0] + rx1[0]) / 2;
      ey = (ry0[0] + ry1[0]) / 2;
      run_frame(1'b1, ex, ey);
      apb_read(`REG_COM, com_word(ex, ey), 1'b0);
      apb_write(`REG_CTRL, 32'h5, 1'b0);
      ex = (rx0[1] + rx1[1]) / 2;
      ey = (ry0[1] + ry1[1]) / 2;
      run_frame(1'b1, ex, ey);
      apb_read(`REG_COM, com_word(ex, ey), 1'b0);

      // dim red 0x78 is below LOWER and then tracking is off with bright red
      clear_rects();
      place_rect(0, 0, PIX - 1, 16'h7800);
      apb_write(`REG_CTRL, 32'h1, 1'b0);
      run_frame(1'b0, 0, 0);
      apb_read(`REG_COM, com_word(ex, ey), 1'b0);  // still the blue result
      place_rect(0, 0, PIX - 1, 16'hF800);
      apb_write(`REG_CTRL, 32'h0, 1'b0);
      run_frame(1'b0, 0, 0);
      apb_read(`REG_COM, com_word(ex, ey), 1'b0);

      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: blob_tracker.f
+incdir+rtl
rtl/blob_tracker_pkg.sv
rtl/pixel_if.sv
rtl/serial_divider.sv
rtl/pixel_reconstruct.sv
rtl/color_threshold.sv
rtl/center_of_mass.sv
rtl/apb_config_regs.sv
rtl/blob_tracker_top.sv
tb/tb_blob_tracker.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the blob tracker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f blob_tracker.f \
   --top-module tb_blob_tracker -o sim_tb_blob_tracker

sim_out=$(./obj_dir/sim_tb_blob_tracker)
echo "$sim_out"

if echo "$sim_out" | grep -qx "All tests passed"; then
   exit 0
else
   exit 1
fi
